/* source/bp_cfg.svh */
// Table sizes must be powers of two; BP_GHR_BITS needs at least 2 bits and BP_XLEN stays at 32
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Pc and target width
`define BP_XLEN 32

// Direct-mapped buffer entry count
`define BP_BTB_ENTRIES 32

// Global history length
// The counter table holds 2**BP_GHR_BITS entries
`define BP_GHR_BITS 3

`endif

/* source/bp_pkg.sv */
// Opcode values follow the RV32I major opcodes; any other opcode must be driven as OP_OTHER
`default_nettype none

`include "bp_cfg.svh"

package bp_pkg;

    // RISC-V major opcodes seen by the predictor
    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Control-flow class held in a buffer entry
    typedef enum logic [1:0] {
        CF_NONE   = 2'b00,
        CF_JUMP   = 2'b01,
        CF_BRANCH = 2'b10
    } cf_kind_e;

    typedef struct packed {
        logic                valid;
        cf_kind_e            kind;
        logic [`BP_XLEN-1:0] tag;
        logic [`BP_XLEN-1:0] target;
    } btb_entry_t;

    // Upper bit gives the taken prediction
    typedef logic [1:0] counter_t;

endpackage

`default_nettype wire

/* source/bp_update_if.sv */
// One write strobe per resolved control-flow instruction with no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

interface bp_update_if
    import bp_pkg::*;
();

    logic                    valid;
    logic [`BP_XLEN-1:0]     pc;
    opcode_e                 opcode;
    logic [`BP_XLEN-1:0]     target;
    logic                    taken;
    logic [`BP_GHR_BITS-1:0] pht_index;

    // Execute stage side
    modport source (
        output valid, pc, opcode, target, taken, pht_index
    );

    // Both prediction tables
    modport sink (
        input valid, pc, opcode, target, taken, pht_index
    );

endinterface

`default_nettype wire

/* source/target_buffer.sv */
// Direct-mapped with overwrite on conflict; the full pc is kept as tag so aliases never hit
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module target_buffer
    import bp_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic [`BP_XLEN-1:0] pc_i,
    bp_update_if.sink                upd,
    output logic                     hit_o,
    output cf_kind_e                 kind_o,
    output logic [`BP_XLEN-1:0]      target_o
);

    localparam int IDX_BITS = $clog2(`BP_BTB_ENTRIES);

    btb_entry_t entries [`BP_BTB_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    btb_entry_t          rd_entry;

    logic [IDX_BITS-1:0] wr_idx;
    btb_entry_t          wr_old;
    btb_entry_t          wr_new;
    logic                upd_is_cf;
    logic                entry_differs;
    logic                wr_en;

    // Fetch lookup
    // Index skips the two byte-offset bits
    assign rd_idx   = pc_i[IDX_BITS+1:2];
    assign rd_entry = entries[rd_idx];

    assign hit_o    = rd_entry.valid && (rd_entry.tag == pc_i);
    assign kind_o   = hit_o ? rd_entry.kind : CF_NONE;
    assign target_o = rd_entry.target;

    // Execute-stage allocate
    assign wr_idx = upd.pc[IDX_BITS+1:2];
    assign wr_old = entries[wr_idx];

    always_comb begin
        unique case (upd.opcode)
            OP_JAL, OP_JALR, OP_BRANCH: upd_is_cf = 1'b1;
            default:                    upd_is_cf = 1'b0;
        endcase
    end

    // Skip the write when the entry already holds this pc and target
    assign entry_differs = !wr_old.valid
                        || (wr_old.tag != upd.pc)
                        || (wr_old.target != upd.target);

    assign wr_en = upd.valid && upd_is_cf && entry_differs;

    always_comb begin
        wr_new.valid  = 1'b1;
        wr_new.kind   = (upd.opcode == OP_BRANCH) ? CF_BRANCH : CF_JUMP;
        wr_new.tag    = upd.pc;
        wr_new.target = upd.target;
    end

    // Only the valid bits are cleared on reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (wr_en) begin
            entries[wr_idx] <= wr_new;
        end
    end

endmodule

`default_nettype wire

/* source/gshare_predictor.sv */
// Updates trust the returned pht_index; only BRANCH updates touch counters and history
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module gshare_predictor
    import bp_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic [`BP_XLEN-1:0]     pc_i,
    bp_update_if.sink                    upd,
    input  wire logic                    history_clear_i,
    output logic                         counter_taken_o,
    output logic [`BP_GHR_BITS-1:0]      index_o
);

    localparam int PHT_DEPTH = 1 << `BP_GHR_BITS;

    counter_t                pht [PHT_DEPTH];
    logic [`BP_GHR_BITS-1:0] ghr;
    logic [`BP_GHR_BITS-1:0] rd_idx;

    logic                    branch_upd;
    counter_t                ctr_old;
    counter_t                ctr_new;

    // Low pc bits above the byte offset hashed with history
    assign rd_idx          = pc_i[`BP_GHR_BITS+1:2] ^ ghr;
    assign index_o         = rd_idx;
    assign counter_taken_o = pht[rd_idx][1];

    assign branch_upd = upd.valid && (upd.opcode == OP_BRANCH);
    assign ctr_old    = pht[upd.pht_index];

    // Saturating step toward the resolved outcome
    always_comb begin
        ctr_new = ctr_old;
        if (upd.taken && (ctr_old != 2'b11)) begin
            ctr_new = ctr_old + 2'b01;
        end else if (!upd.taken && (ctr_old != 2'b00)) begin
            ctr_new = ctr_old - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[i] <= 2'b00;
            end
        end else if (branch_upd) begin
            pht[upd.pht_index] <= ctr_new;
        end
    end

    // Clear wins over a shift in the same cycle
    // Newest outcome enters at the top
    always_ff @(posedge clk) begin
        if (reset_i || history_clear_i) begin
            ghr <= '0;
        end else if (branch_upd) begin
            ghr <= {upd.taken, ghr[`BP_GHR_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

/* source/branch_predictor.sv */
// Lookup is combinational from pc_i; the fetch pipeline must return pht_index_o with the update
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module branch_predictor
    import bp_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset_i,

    // Fetch side
    input  wire logic [`BP_XLEN-1:0]     pc_i,
    output logic                         predict_taken_o,
    output logic [`BP_XLEN-1:0]          predict_target_o,
    output logic [`BP_GHR_BITS-1:0]      pht_index_o,

    // Execute side
    input  wire logic                    update_valid_i,
    input  wire logic [`BP_XLEN-1:0]     update_pc_i,
    input  wire opcode_e                 update_opcode_i,
    input  wire logic [`BP_XLEN-1:0]     update_target_i,
    input  wire logic                    update_taken_i,
    input  wire logic [`BP_GHR_BITS-1:0] update_pht_index_i,
    input  wire logic                    history_clear_i
);

    localparam logic [`BP_XLEN-1:0] INSTR_BYTES = 4;

    logic                    buf_hit;
    cf_kind_e                buf_kind;
    logic [`BP_XLEN-1:0]     buf_target;
    logic                    ctr_taken;
    logic [`BP_GHR_BITS-1:0] ctr_index;

    bp_update_if upd_bus ();

    // Source side of the update bus
    assign upd_bus.valid     = update_valid_i;
    assign upd_bus.pc        = update_pc_i;
    assign upd_bus.opcode    = update_opcode_i;
    assign upd_bus.target    = update_target_i;
    assign upd_bus.taken     = update_taken_i;
    assign upd_bus.pht_index = update_pht_index_i;

    target_buffer u_target_buffer (
        .clk      (clk),
        .reset_i  (reset_i),
        .pc_i     (pc_i),
        .upd      (upd_bus),
        .hit_o    (buf_hit),
        .kind_o   (buf_kind),
        .target_o (buf_target)
    );

    gshare_predictor u_gshare_predictor (
        .clk             (clk),
        .reset_i         (reset_i),
        .pc_i            (pc_i),
        .upd             (upd_bus),
        .history_clear_i (history_clear_i),
        .counter_taken_o (ctr_taken),
        .index_o         (ctr_index)
    );

    // Jumps always redirect, branches follow the counter
    always_comb begin
        predict_taken_o  = 1'b0;
        predict_target_o = pc_i + INSTR_BYTES;
        if (buf_hit) begin
            unique case (buf_kind)
                CF_JUMP: begin
                    predict_taken_o  = 1'b1;
                    predict_target_o = buf_target;
                end
                CF_BRANCH: begin
                    predict_taken_o  = ctr_taken;
                    predict_target_o = buf_target;
                end
                default: ;
            endcase
        end
    end

    assign pht_index_o = ctr_index;

endmodule

`default_nettype wire

/* tests/tb_branch_predictor.sv */
// Reads tests/bp_testdata.txt from the project root; lines are U, L or C records with hex fields
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam string DATA_FILE    = "tests/bp_testdata.txt";
    localparam int    RESET_CYCLES = 5;
    localparam int    CYCLES_EACH  = 5;

    typedef struct {
        byte                     kind;
        logic [`BP_XLEN-1:0]     pc;
        opcode_e                 op;
        logic [`BP_XLEN-1:0]     target;
        logic                    taken;
        logic [`BP_GHR_BITS-1:0] index;
        int                      line_no;
    } record_t;

    logic                    clk;
    logic                    reset_i;
    logic [`BP_XLEN-1:0]     pc_i;
    logic                    update_valid_i;
    logic [`BP_XLEN-1:0]     update_pc_i;
    opcode_e                 update_opcode_i;
    logic [`BP_XLEN-1:0]     update_target_i;
    logic                    update_taken_i;
    logic [`BP_GHR_BITS-1:0] update_pht_index_i;
    logic                    history_clear_i;
    logic                    predict_taken_o;
    logic [`BP_XLEN-1:0]     predict_target_o;
    logic [`BP_GHR_BITS-1:0] pht_index_o;

    record_t records [$];
    bit      records_loaded = 1'b0;
    int      pass_count = 0;
    int      fail_count = 0;
    int      bad_records = 0;
    int      lookup_count = 0;

    branch_predictor dut (
        .clk                (clk),
        .reset_i            (reset_i),
        .pc_i               (pc_i),
        .predict_taken_o    (predict_taken_o),
        .predict_target_o   (predict_target_o),
        .pht_index_o        (pht_index_o),
        .update_valid_i     (update_valid_i),
        .update_pc_i        (update_pc_i),
        .update_opcode_i    (update_opcode_i),
        .update_target_i    (update_target_i),
        .update_taken_i     (update_taken_i),
        .update_pht_index_i (update_pht_index_i),
        .history_clear_i    (history_clear_i)
    );

    always #10 clk = ~clk;

    function automatic bit known_opcode(input logic [6:0] op);
        return (op == 7'h00) || (op == 7'h63) || (op == 7'h67) || (op == 7'h6f);
    endfunction

    task automatic load_records();
        int         fd;
        int         got;
        int         line_no;
        string      line;
        string      body;
        byte        c;
        logic [6:0] op_raw;
        record_t    r;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the data file %s", DATA_FILE);
            bad_records++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            line_no++;
            if (got == 0 || line.len() == 0) continue;
            c = line.getc(0);
            // Comment and blank lines
            if (c == "#" || c == "\n" || c == "\r" || c == " ") continue;
            body      = line.substr(1, line.len() - 1);
            r.kind    = c;
            r.line_no = line_no;
            got       = 0;
            case (c)
                "U": begin
                    got = $sscanf(body, "%h %h %h %h %h",
                                  r.pc, op_raw, r.target, r.taken, r.index);
                    if (got == 5 && !known_opcode(op_raw)) got = 0;
                    r.op = opcode_e'(op_raw);
                    if (got != 5) got = 0;
                end
                "L": got = ($sscanf(body, "%h %h %h %h",
                                    r.pc, r.taken, r.target, r.index) == 4) ? 1 : 0;
                "C": got = 1;
                default: got = 0;
            endcase
            if (got == 0) begin
                $display("Malformed record on line %0d of %s", line_no, DATA_FILE);
                bad_records++;
            end else begin
                records.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_taken(input logic expected, input logic actual, output bit ok);
        ok = (actual === expected);
        if (!ok) $display("ERROR at %0t: predict_taken_o expected %0b, got %0b",
                          $time, expected, actual);
    endtask

    task automatic check_target(input logic [`BP_XLEN-1:0] expected,
                                input logic [`BP_XLEN-1:0] actual, output bit ok);
        ok = (actual === expected);
        if (!ok) $display("ERROR at %0t: predict_target_o expected %h, got %h",
                          $time, expected, actual);
    endtask

    task automatic check_index(input logic [`BP_GHR_BITS-1:0] expected,
                               input logic [`BP_GHR_BITS-1:0] actual, output bit ok);
        ok = (actual === expected);
        if (!ok) $display("ERROR at %0t: pht_index_o expected %h, got %h",
                          $time, expected, actual);
    endtask

    // One strobe cycle, the tables write at the following edge
    task automatic apply_update(input record_t r);
        @(posedge clk);
        update_valid_i     <= 1'b1;
        update_pc_i        <= r.pc;
        update_opcode_i    <= r.op;
        update_target_i    <= r.target;
        update_taken_i     <= r.taken;
        update_pht_index_i <= r.index;
        @(posedge clk);
        update_valid_i     <= 1'b0;
    endtask

    task automatic pulse_history_clear();
        @(posedge clk);
        history_clear_i <= 1'b1;
        @(posedge clk);
        history_clear_i <= 1'b0;
    endtask

    task automatic check_lookup(input record_t r);
        bit ok_taken;
        bit ok_target;
        bit ok_index;
        @(posedge clk);
        pc_i <= r.pc;
        @(posedge clk);
        check_taken(r.taken, predict_taken_o, ok_taken);
        check_target(r.target, predict_target_o, ok_target);
        check_index(r.index, pht_index_o, ok_index);
        lookup_count++;
        if (ok_taken && ok_target && ok_index) begin
            pass_count++;
            $display("Lookup %0d (line %0d) pc %h: ok", lookup_count, r.line_no, r.pc);
        end else begin
            fail_count++;
            $display("Lookup %0d (line %0d) pc %h: mismatch", lookup_count, r.line_no, r.pc);
        end
    endtask

    initial begin
        clk                = 1'b0;
        reset_i            <= 1'b1;
        pc_i               <= '0;
        update_valid_i     <= 1'b0;
        update_pc_i        <= '0;
        update_opcode_i    <= OP_OTHER;
        update_target_i    <= '0;
        update_taken_i     <= 1'b0;
        update_pht_index_i <= '0;
        history_clear_i    <= 1'b0;
        void'($urandom(32'hf6841a98));
        load_records();
        records_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        foreach (records[i]) begin
            // Idle gap between records
            repeat ($urandom_range(3, 0)) @(posedge clk);
            case (records[i].kind)
                "U":     apply_update(records[i]);
                "C":     pulse_history_clear();
                default: check_lookup(records[i]);
            endcase
        end
        @(posedge clk);
        $display("Summary: %0d lookups passed, %0d failed, %0d bad records",
                 pass_count, fail_count, bad_records);
        if (fail_count == 0 && bad_records == 0 && pass_count > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the record count
    initial begin
        wait (records_loaded);
        repeat (records.size() * CYCLES_EACH + RESET_CYCLES + 100) @(posedge clk);
        $display("Timeout: the run did not finish within the expected number of cycles");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/bp_testdata.txt */
# U pc opcode target taken pht_index | L pc exp_taken exp_target exp_index | C history clear
# All fields hex; opcodes 6f JAL, 67 JALR, 63 BRANCH, 00 other
L 00000000 0 00000004 0
L 00000014 0 00000018 5
L 0000103c 0 00001040 7
U 00000100 6f 00000200 1 0
L 00000100 1 00000200 0
L 00000180 0 00000184 0
U 00000208 63 00000300 0 2
L 00000208 0 00000300 2
U 00000208 63 00000300 1 2
U 00000208 63 00000300 1 2
L 00000208 0 00000300 4
C
L 00000208 1 00000300 2
U 00000208 63 00000300 1 2
U 00000208 63 00000300 1 2
U 00000208 63 00000300 0 2
C
L 00000208 1 00000300 2
U 00000208 63 00000300 0 2
L 00000208 0 00000300 2
U 0000040c 63 00000500 1 3
L 0000040c 0 00000500 7
U 0000040c 63 00000500 0 7
L 0000040c 0 00000500 1
U 0000040c 63 00000500 1 1
L 0000040c 0 00000500 6
U 00000614 67 00000700 1 0
L 0000040c 0 00000500 6
L 00000614 1 00000700 0
U 00000618 00 00000800 1 3
L 00000618 0 0000061c 3
U 0000040c 63 00000500 1 3
L 0000040c 0 00000500 5
C
L 0000040c 1 00000500 3
U 00000100 6f 00000240 1 0
L 00000100 1 00000240 0
U 00000208 63 00000320 1 2
L 00000208 0 00000320 6

/* all.f */
+incdir+source
source/bp_pkg.sv
source/bp_update_if.sv
source/target_buffer.sv
source/gshare_predictor.sv
source/branch_predictor.sv
tests/tb_branch_predictor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_branch_predictor -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_branch_predictor > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^TEST PASS$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
